// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= fdc_tb
FLAGS     ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

# status comes from the search for the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
logic/fdc_reg_pkg.sv
logic/fdc_cmd_pkg.sv
logic/fdc_host_regs.sv
logic/sector_buffer.sv
logic/fdc_sequencer.sv
logic/fdc_top.sv
verification/fdc_tb.sv

// ==== logic/fdc_cmd_pkg.sv ====
`default_nettype none

// command decode, sequencer states and workhorse protocol codes
package fdc_cmd_pkg;

	// upper command nibble
	// odd step codes also update the track register
	typedef enum logic [3:0] {
		op_restore       = 4'h0,
		op_seek          = 4'h1,
		op_step          = 4'h2,
		op_step_upd      = 4'h3,
		op_step_in       = 4'h4,
		op_step_in_upd   = 4'h5,
		op_step_out      = 4'h6,
		op_step_out_upd  = 4'h7,
		op_read_sector   = 4'h8,
		op_read_sector_m = 4'h9
	} cmd_op_t;

	// sequencer FSM
	typedef enum logic [2:0] {
		idle, wait_cpu, wait_cpuread, fetch, drq_wait, end_cmd, end_ack
	} seq_state_t;

	// --------------------
	// requests to the workhorse
	localparam logic [7:0] req_read = 8'h10;
	localparam logic [7:0] req_nop  = 8'h40;
	localparam logic [7:0] req_ack  = 8'h80;

	// end codes, low nibble of the ack request
	localparam logic [3:0] end_read_done  = 4'd1;
	localparam logic [3:0] end_read_fail  = 4'd3;
	localparam logic [3:0] end_type1_done = 4'd6;

endpackage

`default_nettype wire

// ==== logic/fdc_host_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_host_regs (
	input  wire                     clk,
	input  wire                     cock,
	// host bus
	input  wire                     rd,
	input  wire                     wr,
	input  wire fdc_reg_pkg::reg_addr_t addr,
	input  wire fdc_reg_pkg::byte_t wdata,
	output fdc_reg_pkg::byte_t      rdata,
	// command channel
	output logic                    cmd_valid,
	output fdc_reg_pkg::byte_t      cmd_byte,
	input  wire                     cmd_ready,
	// data register
	output fdc_reg_pkg::byte_t      data_reg,
	output logic                    data_taken,
	input  wire                     buf_byte_valid,
	input  wire fdc_reg_pkg::byte_t buf_byte,
	// track/sector
	input  wire                     track_load,
	input  wire fdc_reg_pkg::byte_t track_value,
	output fdc_reg_pkg::byte_t      sector_reg,
	// status sources
	input  wire                     busy,
	input  wire                     drq,
	input  wire                     head_loaded,
	input  wire                     seek_err,
	input  wire                     crc_err,
	input  wire                     index,
	input  wire                     cmd_mode,
	input  wire fdc_reg_pkg::byte_t head_pos,
	input  wire fdc_reg_pkg::byte_t cpu_status
);
	import fdc_reg_pkg::*;

	byte_t track_reg;
	byte_t status;
	logic  busy_all;

	// pending command counts as busy for the host
	assign busy_all = busy | cmd_valid;

	// every data register read, drq or not
	assign data_taken = rd && (addr == addr_data);

	// --------------------
	// status byte
	always_comb begin
		status = '0;
		status[stat_busy]      = busy_all;
		status[stat_crc]       = crc_err;
		status[stat_seek]      = seek_err;
		status[stat_head]      = head_loaded;
		// image missing
		status[stat_not_ready] = cpu_status[3];
		if (cmd_mode) begin
			// type II view
			status[stat_index_drq]   = drq;
			status[stat_track0_lost] = 1'b0;
		end else begin
			status[stat_index_drq]   = index;
			status[stat_track0_lost] = (head_pos == 8'h00);
		end
	end

	// --------------------
	// control registers
	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			cmd_valid  <= 1'b0;
			track_reg  <= '0;
			sector_reg <= '0;
			rdata      <= '0;
		end else begin
			// handshake with the sequencer
			if (cmd_valid && cmd_ready)
				cmd_valid <= 1'b0;
			if (wr && (addr == addr_cmd_status) && !cmd_valid)
				cmd_valid <= 1'b1;

			// track and sector locked while busy
			if (wr && (addr == addr_sector) && !busy_all)
				sector_reg <= wdata;
			if (track_load)
				track_reg <= track_value;
			else if (wr && (addr == addr_track) && !busy_all)
				track_reg <= wdata;

			// registered read mux
			if (rd) begin
				case (addr)
					addr_cmd_status: rdata <= status;
					addr_track:      rdata <= track_reg;
					addr_sector:     rdata <= sector_reg;
					addr_data:       rdata <= data_reg;
					default:         rdata <= 8'hff;
				endcase
			end
		end
	end

	// payload, no reset
	always_ff @(posedge clk) begin
		if (wr && (addr == addr_cmd_status) && !cmd_valid)
			cmd_byte <= wdata;
		// sequencer byte wins over a host write
		if (buf_byte_valid)
			data_reg <= buf_byte;
		else if (wr && (addr == addr_data))
			data_reg <= wdata;
	end

	// a latched command stays until the sequencer takes it
	a_cmd_hold: assert property (@(posedge clk) disable iff (cock)
		cmd_valid && !cmd_ready |=> cmd_valid)
		else $error("cmd_valid dropped without handshake");

endmodule

`default_nettype wire

// ==== logic/fdc_reg_pkg.sv ====
`default_nettype none

// host side register map and status layout
package fdc_reg_pkg;

	// --------------------
	// bus widths
	localparam int byte_w = 8;
	localparam int reg_addr_w = 3;

	// one host data byte
	typedef logic [byte_w-1:0] byte_t;

	// host register addresses
	typedef enum logic [reg_addr_w-1:0] {
		addr_cmd_status = 3'd0,
		addr_track      = 3'd1,
		addr_sector     = 3'd2,
		addr_data       = 3'd3
	} reg_addr_t;

	// --------------------
	// status bit positions
	// index/drq and track0/lost data share a slot, chosen by cmd_mode
	localparam int stat_busy        = 0;
	localparam int stat_index_drq   = 1;
	localparam int stat_track0_lost = 2;
	localparam int stat_crc         = 3;
	localparam int stat_seek        = 4;
	localparam int stat_head        = 5;
	// bit 6 is write protect, never set
	localparam int stat_not_ready   = 7;

endpackage

`default_nettype wire

// ==== logic/fdc_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_sequencer #(
	parameter int SECTOR_SIZE = 1024,
	localparam int buf_addr_w = $clog2(SECTOR_SIZE)
) (
	input  wire                     clk,
	input  wire                     cock,
	// command channel
	input  wire                     cmd_valid,
	input  wire fdc_reg_pkg::byte_t cmd_byte,
	output logic                    cmd_ready,
	// data register
	input  wire fdc_reg_pkg::byte_t data_reg,
	input  wire                     data_taken,
	// sector buffer
	output logic                    buf_byte_valid,
	output fdc_reg_pkg::byte_t      buf_byte,
	output logic [buf_addr_w-1:0]   buf_rd_addr,
	input  wire fdc_reg_pkg::byte_t buf_rd_data,
	// track register update
	output logic                    track_load,
	output fdc_reg_pkg::byte_t      track_value,
	// status
	output logic                    busy,
	output logic                    drq,
	output logic                    head_loaded,
	output logic                    seek_err,
	output logic                    crc_err,
	output logic                    index,
	output logic                    cmd_mode,
	output fdc_reg_pkg::byte_t      head_pos,
	output logic                    irq,
	// workhorse
	output fdc_reg_pkg::byte_t      cpu_request,
	input  wire fdc_reg_pkg::byte_t cpu_status
);
	import fdc_reg_pkg::*;
	import fdc_cmd_pkg::*;

	seq_state_t           state;
	cmd_op_t              op;
	logic                 step_dir;
	logic                 step_dir_now;
	byte_t                head_next;
	logic [buf_addr_w:0]  byte_cnt;
	logic                 ram_ready;
	logic [3:0]           end_code;
	logic                 read_ok;
	logic                 read_fail;

	assign op = cmd_op_t'(cmd_byte[7:4]);
	assign cmd_ready = (state == idle);

	// explicit direction overrides the stored one, 0 is inward
	assign step_dir_now = cmd_byte[6] ? cmd_byte[5] : step_dir;
	assign head_next = step_dir_now ? head_pos - 8'd1 : head_pos + 8'd1;

	// workhorse verdict on a read
	assign read_fail = cpu_status[3] || (cpu_status[1:0] == 2'b01);
	assign read_ok = (cpu_status[1:0] == 2'b11);

	// byte goes to the data register on the second fetch cycle
	assign buf_byte_valid = (state == fetch) && ram_ready;
	assign buf_byte = buf_rd_data;

	always_ff @(posedge clk or posedge cock) begin
		if (cock) begin
			state       <= idle;
			head_pos    <= 8'hff;
			step_dir    <= 1'b0;
			byte_cnt    <= '0;
			buf_rd_addr <= '0;
			ram_ready   <= 1'b0;
			end_code    <= '0;
			track_load  <= 1'b0;
			track_value <= '0;
			busy        <= 1'b0;
			drq         <= 1'b0;
			head_loaded <= 1'b0;
			seek_err    <= 1'b0;
			crc_err     <= 1'b0;
			index       <= 1'b0;
			cmd_mode    <= 1'b0;
			irq         <= 1'b0;
			cpu_request <= req_ack;
		end else begin
			track_load <= 1'b0;
			case (state)
				// --------------------
				// command accept
				idle: begin
					if (cmd_valid) begin
						cmd_mode <= cmd_byte[7];
						irq      <= 1'b0;
						index    <= 1'b0;
						seek_err <= 1'b0;
						crc_err  <= 1'b0;
						end_code <= end_type1_done;
						case (op)
							op_restore, op_seek, op_step, op_step_upd, op_step_in,
							op_step_in_upd, op_step_out, op_step_out_upd: begin
								busy        <= 1'b1;
								index       <= 1'b1;
								head_loaded <= cmd_byte[3];
								cpu_request <= req_nop | {4'h0, cmd_byte[7:4]};
								state       <= wait_cpu;
								if (op == op_restore) begin
									head_pos    <= '0;
									track_load  <= 1'b1;
									track_value <= '0;
								end else if (op == op_seek) begin
									head_pos <= data_reg;
								end else begin
									// remember direction for plain step
									if (cmd_byte[6])
										step_dir <= cmd_byte[5];
									head_pos <= head_next;
									if (cmd_byte[4]) begin
										track_load  <= 1'b1;
										track_value <= head_next;
									end
								end
							end
							op_read_sector, op_read_sector_m: begin
								busy        <= 1'b1;
								head_loaded <= 1'b1;
								byte_cnt    <= (buf_addr_w + 1)'(SECTOR_SIZE);
								buf_rd_addr <= '0;
								cpu_request <= req_read;
								state       <= wait_cpuread;
							end
							// unsupported, stay idle
							default: busy <= 1'b0;
						endcase
					end
				end
				// type I, wait for done
				wait_cpu: begin
					if (cpu_status[0])
						state <= end_cmd;
				end
				// read, wait for image access
				wait_cpuread: begin
					if (read_fail) begin
						seek_err <= 1'b1;
						crc_err  <= cpu_status[2];
						end_code <= end_read_fail;
						state    <= end_cmd;
					end else if (read_ok) begin
						ram_ready <= 1'b0;
						state     <= fetch;
					end
				end
				// --------------------
				// buffer to host
				fetch: begin
					if (!ram_ready) begin
						// ram read in flight
						ram_ready <= 1'b1;
					end else begin
						ram_ready <= 1'b0;
						drq       <= 1'b1;
						state     <= drq_wait;
					end
				end
				// hold byte until the host reads it
				drq_wait: begin
					if (data_taken && drq) begin
						drq <= 1'b0;
						if (byte_cnt == 1) begin
							end_code <= end_read_done;
							state    <= end_cmd;
						end else begin
							byte_cnt    <= byte_cnt - 1'b1;
							buf_rd_addr <= buf_rd_addr + 1'b1;
							state       <= fetch;
						end
					end
				end
				// --------------------
				// end exchange
				end_cmd: begin
					irq         <= 1'b1;
					busy        <= 1'b0;
					cpu_request <= {req_ack[7:4], end_code};
					state       <= end_ack;
				end
				end_ack: begin
					// workhorse clears status to acknowledge
					if (cpu_status == 8'h00) begin
						cpu_request <= '0;
						state       <= idle;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	a_drq_state: assert property (@(posedge clk) disable iff (cock)
		drq |-> (state == drq_wait))
		else $error("drq high outside drq_wait");

	a_irq_busy: assert property (@(posedge clk) disable iff (cock)
		$rose(irq) |-> !busy)
		else $error("irq rose while busy");

endmodule

`default_nettype wire

// ==== logic/fdc_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_top #(
	parameter int SECTOR_SIZE = 1024,
	localparam int buf_addr_w = $clog2(SECTOR_SIZE)
) (
	input  wire                     clk,
	input  wire                     cock,
	// host bus
	input  wire                     rd,
	input  wire                     wr,
	input  wire fdc_reg_pkg::reg_addr_t addr,
	input  wire fdc_reg_pkg::byte_t wdata,
	output fdc_reg_pkg::byte_t      rdata,
	output logic                    irq,
	output logic                    drq,
	// workhorse
	output fdc_reg_pkg::byte_t      cpu_request,
	output fdc_reg_pkg::byte_t      cpu_track,
	output fdc_reg_pkg::byte_t      cpu_sector,
	input  wire fdc_reg_pkg::byte_t cpu_status,
	// buffer fill from the workhorse
	input  wire                     buf_wr_en,
	input  wire [buf_addr_w-1:0]    buf_wr_addr,
	input  wire fdc_reg_pkg::byte_t buf_wr_data
);
	import fdc_reg_pkg::*;

	// command channel
	logic  cmd_valid;
	logic  cmd_ready;
	byte_t cmd_byte;

	// data path
	byte_t                 data_reg;
	logic                  data_taken;
	logic                  buf_byte_valid;
	byte_t                 buf_byte;
	logic [buf_addr_w-1:0] buf_rd_addr;
	byte_t                 buf_rd_data;

	// track update and status
	logic  track_load;
	byte_t track_value;
	logic  busy;
	logic  head_loaded;
	logic  seek_err;
	logic  crc_err;
	logic  index;
	logic  cmd_mode;

	fdc_host_regs u_host_regs (
		.clk(clk), .cock(cock),
		.rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .rdata(rdata),
		.cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .cmd_ready(cmd_ready),
		.data_reg(data_reg), .data_taken(data_taken),
		.buf_byte_valid(buf_byte_valid), .buf_byte(buf_byte),
		.track_load(track_load), .track_value(track_value),
		.sector_reg(cpu_sector),
		.busy(busy), .drq(drq), .head_loaded(head_loaded),
		.seek_err(seek_err), .crc_err(crc_err), .index(index),
		.cmd_mode(cmd_mode), .head_pos(cpu_track), .cpu_status(cpu_status)
	);

	sector_buffer #(.SECTOR_SIZE(SECTOR_SIZE)) u_sector_buffer (
		.clk(clk),
		.wr_en(buf_wr_en), .wr_addr(buf_wr_addr), .wr_data(buf_wr_data),
		.rd_addr(buf_rd_addr), .rd_data(buf_rd_data)
	);

	fdc_sequencer #(.SECTOR_SIZE(SECTOR_SIZE)) u_sequencer (
		.clk(clk), .cock(cock),
		.cmd_valid(cmd_valid), .cmd_byte(cmd_byte), .cmd_ready(cmd_ready),
		.data_reg(data_reg), .data_taken(data_taken),
		.buf_byte_valid(buf_byte_valid), .buf_byte(buf_byte),
		.buf_rd_addr(buf_rd_addr), .buf_rd_data(buf_rd_data),
		.track_load(track_load), .track_value(track_value),
		.busy(busy), .drq(drq), .head_loaded(head_loaded),
		.seek_err(seek_err), .crc_err(crc_err), .index(index),
		.cmd_mode(cmd_mode), .head_pos(cpu_track), .irq(irq),
		.cpu_request(cpu_request), .cpu_status(cpu_status)
	);

endmodule

`default_nettype wire

// ==== logic/sector_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module sector_buffer #(
	parameter int SECTOR_SIZE = 1024,
	localparam int buf_addr_w = $clog2(SECTOR_SIZE)
) (
	input  wire                     clk,
	// workhorse side
	input  wire                     wr_en,
	input  wire [buf_addr_w-1:0]    wr_addr,
	input  wire fdc_reg_pkg::byte_t wr_data,
	// sequencer side
	input  wire [buf_addr_w-1:0]    rd_addr,
	output fdc_reg_pkg::byte_t      rd_data
);
	import fdc_reg_pkg::*;

	byte_t mem [SECTOR_SIZE];

	// one write port, one registered read port
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
		// data one cycle after the address
		rd_data <= mem[rd_addr];
	end

endmodule

`default_nettype wire

// ==== verification/fdc_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fdc_tb;
	import fdc_reg_pkg::*;
	import fdc_cmd_pkg::*;

	localparam int sector_size = 16;
	localparam int addr_w = $clog2(sector_size);
	// cycles allowed per wait
	localparam int wait_limit = 200;

	logic              clk;
	logic              cock;
	logic              rd;
	logic              wr;
	reg_addr_t         addr;
	byte_t             wdata;
	byte_t             rdata;
	logic              irq;
	logic              drq;
	byte_t             cpu_request;
	byte_t             cpu_track;
	byte_t             cpu_sector;
	byte_t             cpu_status;
	logic              buf_wr_en;
	logic [addr_w-1:0] buf_wr_addr;
	byte_t             buf_wr_data;

	integer seed;
	int     test_errors;
	int     total_errors;
	int     tests_run;

	fdc_top #(.SECTOR_SIZE(sector_size)) u_fdc_top (
		.clk(clk), .cock(cock),
		.rd(rd), .wr(wr), .addr(addr), .wdata(wdata), .rdata(rdata),
		.irq(irq), .drq(drq),
		.cpu_request(cpu_request), .cpu_track(cpu_track), .cpu_sector(cpu_sector),
		.cpu_status(cpu_status),
		.buf_wr_en(buf_wr_en), .buf_wr_addr(buf_wr_addr), .buf_wr_data(buf_wr_data)
	);

	// 40 ns period
	always #20 clk = ~clk;

	// --------------------
	// host bus
	task automatic host_write(input reg_addr_t a, input byte_t d);
		@(posedge clk);
		addr  <= a;
		wdata <= d;
		wr    <= 1'b1;
		@(posedge clk);
		wr <= 1'b0;
	endtask

	// rdata valid one cycle after the read edge
	task automatic host_read(input reg_addr_t a, output byte_t d);
		@(posedge clk);
		addr <= a;
		rd   <= 1'b1;
		@(posedge clk);
		rd <= 1'b0;
		@(negedge clk);
		d = rdata;
	endtask

	task automatic report_mismatch(input string name, input byte_t expected, input byte_t actual);
		$display("Error %s: expected %h, actual %h", name, expected, actual);
		test_errors++;
	endtask

	// --------------------
	// bounded waits sampled on the falling edge
	task automatic wait_request(input byte_t expected, input string name);
		int n;
		n = 0;
		while (cpu_request !== expected && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (cpu_request !== expected) begin
			$display("%s: timed out waiting for cpu_request %h", name, expected);
			test_errors++;
		end
	endtask

	task automatic poll_irq(input string name);
		int n;
		n = 0;
		while (irq !== 1'b1 && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (irq !== 1'b1) begin
			$display("%s: timed out waiting for irq", name);
			test_errors++;
		end
	endtask

	task automatic poll_drq(input string name);
		int n;
		n = 0;
		while (drq !== 1'b1 && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (drq !== 1'b1) begin
			$display("%s: timed out waiting for drq", name);
			test_errors++;
		end
	endtask

	// --------------------
	// workhorse model
	task automatic drive_status(input byte_t s);
		@(posedge clk);
		cpu_status <= s;
	endtask

	// type I request carries the opcode in the low nibble
	task automatic start_type1(input byte_t cmd, input byte_t request, input string name);
		host_write(addr_cmd_status, cmd);
		wait_request(request, name);
	endtask

	// done then the ack exchange with end code 6
	task automatic finish_type1(input string name);
		drive_status(8'h01);
		poll_irq(name);
		if (cpu_request !== 8'h86)
			report_mismatch(name, 8'h86, cpu_request);
		drive_status(8'h00);
		wait_request(8'h00, name);
	endtask

	task automatic end_test(input string name);
		$display("%s: %s, %0d errors", name, (test_errors == 0) ? "ok" : "bad", test_errors);
		total_errors += test_errors;
		tests_run++;
		test_errors = 0;
	endtask

	// --------------------
	// directed tests
	task automatic test_reset();
		byte_t v;
		if (irq !== 1'b0)
			report_mismatch("test_reset", 8'h00, {7'h0, irq});
		if (drq !== 1'b0)
			report_mismatch("test_reset", 8'h00, {7'h0, drq});
		if (cpu_request !== req_ack)
			report_mismatch("test_reset", req_ack, cpu_request);
		if (rdata !== 8'h00)
			report_mismatch("test_reset", 8'h00, rdata);
		// head parked off track 0
		if (cpu_track !== 8'hff)
			report_mismatch("test_reset", 8'hff, cpu_track);
		host_read(addr_cmd_status, v);
		if (v[stat_busy] !== 1'b0)
			report_mismatch("test_reset", 8'h00, v & 8'h01);
		host_read(addr_track, v);
		if (v !== 8'h00)
			report_mismatch("test_reset", 8'h00, v);
		end_test("test_reset");
	endtask

	task automatic test_registers();
		byte_t v;
		host_write(addr_track, 8'h5a);
		host_read(addr_track, v);
		if (v !== 8'h5a)
			report_mismatch("test_registers", 8'h5a, v);
		host_write(addr_sector, 8'h2c);
		host_read(addr_sector, v);
		if (v !== 8'h2c)
			report_mismatch("test_registers", 8'h2c, v);
		if (cpu_sector !== 8'h2c)
			report_mismatch("test_registers", 8'h2c, cpu_sector);
		// step out stays busy until the workhorse answers
		start_type1(8'h60, 8'h46, "test_registers");
		host_write(addr_track, 8'h77);
		finish_type1("test_registers");
		host_read(addr_track, v);
		if (v !== 8'h5a)
			report_mismatch("test_registers", 8'h5a, v);
		// one step out from the reset position
		if (cpu_track !== 8'hfe)
			report_mismatch("test_registers", 8'hfe, cpu_track);
		end_test("test_registers");
	endtask

	task automatic test_restore_step();
		byte_t v;
		start_type1(8'h00, 8'h40, "test_restore_step");
		finish_type1("test_restore_step");
		host_read(addr_track, v);
		if (v !== 8'h00)
			report_mismatch("test_restore_step", 8'h00, v);
		// mode 0 status shows track0
		host_read(addr_cmd_status, v);
		if (v[stat_track0_lost] !== 1'b1)
			report_mismatch("test_restore_step", 8'h04, v & 8'h04);
		// step in with track update
		start_type1(8'h50, 8'h45, "test_restore_step");
		finish_type1("test_restore_step");
		host_read(addr_track, v);
		if (v !== 8'h01)
			report_mismatch("test_restore_step", 8'h01, v);
		if (cpu_track !== 8'h01)
			report_mismatch("test_restore_step", 8'h01, cpu_track);
		// step out moves the head only
		start_type1(8'h60, 8'h46, "test_restore_step");
		finish_type1("test_restore_step");
		if (cpu_track !== 8'h00)
			report_mismatch("test_restore_step", 8'h00, cpu_track);
		host_read(addr_track, v);
		if (v !== 8'h01)
			report_mismatch("test_restore_step", 8'h01, v);
		end_test("test_restore_step");
	endtask

	task automatic test_seek();
		// target goes through the data register
		host_write(addr_data, 8'h05);
		start_type1(8'h10, 8'h41, "test_seek");
		finish_type1("test_seek");
		if (cpu_track !== 8'h05)
			report_mismatch("test_seek", 8'h05, cpu_track);
		end_test("test_seek");
	endtask

	task automatic test_read_sector();
		byte_t exp_data [sector_size];
		byte_t v;
		byte_t s;
		// workhorse fills the buffer
		for (int i = 0; i < sector_size; i++) begin
			exp_data[i] = byte_t'($random(seed));
			@(posedge clk);
			buf_wr_en   <= 1'b1;
			buf_wr_addr <= addr_w'(i);
			buf_wr_data <= exp_data[i];
		end
		@(posedge clk);
		buf_wr_en <= 1'b0;
		host_write(addr_cmd_status, 8'h80);
		wait_request(req_read, "test_read_sector");
		drive_status(8'h03);
		// one byte per drq
		for (int i = 0; i < sector_size; i++) begin
			poll_drq("test_read_sector");
			// mode 1 status carries drq in bit 1
			if (i == 0) begin
				host_read(addr_cmd_status, s);
				if ((s & 8'h03) !== 8'h03)
					report_mismatch("test_read_sector", 8'h03, s & 8'h03);
			end
			host_read(addr_data, v);
			if (v !== exp_data[i])
				report_mismatch("test_read_sector", exp_data[i], v);
		end
		poll_irq("test_read_sector");
		if (cpu_request !== 8'h81)
			report_mismatch("test_read_sector", 8'h81, cpu_request);
		drive_status(8'h00);
		wait_request(8'h00, "test_read_sector");
		end_test("test_read_sector");
	endtask

	task automatic test_read_fail();
		byte_t v;
		host_write(addr_cmd_status, 8'h80);
		wait_request(req_read, "test_read_fail");
		// done without ok and with crc error
		drive_status(8'h05);
		poll_irq("test_read_fail");
		if (cpu_request !== 8'h83)
			report_mismatch("test_read_fail", 8'h83, cpu_request);
		// mode 1 view with seek and crc set
		host_read(addr_cmd_status, v);
		if ((v & 8'h1b) !== 8'h18)
			report_mismatch("test_read_fail", 8'h18, v & 8'h1b);
		drive_status(8'h00);
		wait_request(8'h00, "test_read_fail");
		end_test("test_read_fail");
	endtask

	// --------------------
	// main sequence
	initial begin
		clk = 1'b0;
		cock <= 1'b1;
		rd <= 1'b0;
		wr <= 1'b0;
		addr <= addr_cmd_status;
		wdata <= 8'h00;
		cpu_status <= 8'h00;
		buf_wr_en <= 1'b0;
		buf_wr_addr <= '0;
		buf_wr_data <= 8'h00;
		seed = 31;
		test_errors = 0;
		total_errors = 0;
		tests_run = 0;
		// reset for two cycles
		repeat (2) @(posedge clk);
		cock <= 1'b0;
		@(negedge clk);
		test_reset();
		test_registers();
		test_restore_step();
		test_seek();
		test_read_sector();
		test_read_fail();
		$display("tests run: %0d, errors: %0d", tests_run, total_errors);
		if (total_errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire
